// ==== sources.f ====
+incdir+include
source/isa_pkg.sv
source/pipe_pkg.sv
source/inst_decode.sv
source/reg_file.sv
source/forward_ctrl.sv
source/id_stage.sv
source/ex_stage.sv
source/cpu_core.sv
bench/clock_gen.sv
bench/cpu_core_tb.sv

// ==== Bender.yml ====
package:
  name: cpu_core

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/isa_pkg.sv
      - source/pipe_pkg.sv
      - source/inst_decode.sv
      - source/reg_file.sv
      - source/forward_ctrl.sv
      - source/id_stage.sv
      - source/ex_stage.sv
      - source/cpu_core.sv
  - target: test
    files:
      - bench/clock_gen.sv
      - bench/cpu_core_tb.sv

// ==== bench/cpu_core_tb.sv ====
// ####################################################################
// Table-driven testbench for the decode and execute core
// ####################################################################
`timescale 1ns/1ps

module cpu_core_tb;

	logic                clk, rst_n, instr_valid;
	pipe_pkg::word_t     instr, pc;
	logic                wb_valid, j_valid, halted;
	pipe_pkg::reg_addr_t wb_addr;
	pipe_pkg::word_t     wb_data, j_pc;

	// Stimulus table with one row per strobe
	pipe_pkg::word_t     tb_instr[$];
	pipe_pkg::word_t     tb_pc[$];
	int                  tb_gap[$];
	string               tb_label[$];

	// Reference model state and pending results
	pipe_pkg::word_t     ref_regs [16];
	logic                model_halted;
	pipe_pkg::reg_addr_t exp_wb_addr[$];
	pipe_pkg::word_t     exp_wb_data[$];
	pipe_pkg::word_t     exp_j_pc[$];

	int error_count, group_errors, tests_run, tests_failed, seed_state;
	logic table_ready;

	clock_gen clk_gen_i (.clk(clk), .rst_n(rst_n));

	cpu_core cpu_core_i (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.wb_valid(wb_valid), .wb_addr(wb_addr), .wb_data(wb_data),
		.j_valid(j_valid), .j_pc(j_pc), .halted(halted)
	);

	task automatic check(input string name, input logic [31:0] expv, input logic [31:0] actv);
		if (expv !== actv) begin
			$display("error at %0t ns: %s expected %0h, got %0h", $time, name, expv, actv);
			error_count++;
		end
	endtask

	function automatic pipe_pkg::word_t enc_r(input logic [3:0] op,
			input pipe_pkg::reg_addr_t rd, input pipe_pkg::reg_addr_t rs,
			input pipe_pkg::reg_addr_t rt);
		return {op, rd, rs, rt};
	endfunction

	function automatic pipe_pkg::word_t enc_llb(input pipe_pkg::reg_addr_t rd,
			input logic [7:0] imm);
		return {4'd8, rd, imm};
	endfunction

	task automatic add_entry(input string label, input pipe_pkg::word_t ins,
			input pipe_pkg::word_t ipc, input int gap);
		tb_instr.push_back(ins);
		tb_pc.push_back(ipc);
		tb_gap.push_back(gap);
		tb_label.push_back(label);
	endtask

	// Applies one instruction by the ISA rules and queues what the core must report
	task automatic model_apply(input pipe_pkg::word_t ins, input pipe_pkg::word_t ipc);
		pipe_pkg::reg_addr_t rd, rs, rt;
		pipe_pkg::word_t     a, b, res;
		logic                writes;
		rd     = ins[11:8];
		rs     = ins[7:4];
		rt     = ins[3:0];
		a      = ref_regs[rs];
		b      = ref_regs[rt];
		res    = '0;
		writes = 1'b1;
		if (model_halted)
			return;
		case (isa_pkg::opcode_e'(ins[15:12]))
			isa_pkg::op_add: res = a + b;
			isa_pkg::op_sub: res = a - b;
			isa_pkg::op_and: res = a & b;
			isa_pkg::op_nor: res = ~(a | b);
			isa_pkg::op_sll: res = a << rt;
			isa_pkg::op_srl: res = a >> rt;
			isa_pkg::op_sra: res = pipe_pkg::word_t'($signed(a) >>> rt);
			isa_pkg::op_llb: res = {{8{ins[7]}}, ins[7:0]};
			isa_pkg::op_jal: begin
				writes = 1'b0;
				exp_j_pc.push_back(ipc + {{4{ins[11]}}, ins[11:0]});
			end
			isa_pkg::op_jr: begin
				writes = 1'b0;
				exp_j_pc.push_back(a);
			end
			isa_pkg::op_hlt: begin
				writes       = 1'b0;
				model_halted = 1'b1;
			end
			default: writes = 1'b0;
		endcase
		if (writes) begin
			exp_wb_addr.push_back(rd);
			exp_wb_data.push_back(res);
			// r0 keeps zero even though the write is reported
			if (rd != 0)
				ref_regs[rd] = res;
		end
	endtask

	task automatic build_table();
		for (int r = 1; r <= 4; r++)
			add_entry("alu_basic", enc_llb(r, 8'($urandom())), 16'(tb_pc.size()), r == 4 ? 3 : 0);
		add_entry("alu_basic", enc_r(4'd0, 5, 1, 2), 16'h0, 0);
		add_entry("alu_basic", enc_r(4'd1, 6, 3, 4), 16'h0, 0);
		add_entry("alu_basic", enc_r(4'd2, 7, 1, 3), 16'h0, 0);
		add_entry("alu_basic", enc_r(4'd3, 8, 2, 4), 16'h0, 0);
		add_entry("alu_basic", enc_r(4'd0, 0, 1, 2), 16'h0, 3);
		add_entry("alu_basic", enc_r(4'd0, 9, 0, 3), 16'h0, 0);
		add_entry("alu_basic", enc_r(4'd7, 9, 1, 1), 16'h0, 0);
		// Consumer right behind its producer
		add_entry("fwd_gap0", enc_llb(10, 8'($urandom())), 16'h0, 0);
		add_entry("fwd_gap0", enc_r(4'd0, 11, 10, 10), 16'h0, 0);
		add_entry("fwd_gap0", enc_r(4'd1, 12, 11, 10), 16'h0, 0);
		add_entry("fwd_gap0", enc_r(4'd2, 13, 12, 11), 16'h0, 0);
		// One idle cycle between producer and consumer
		add_entry("fwd_gap1", enc_llb(10, 8'($urandom())), 16'h0, 1);
		add_entry("fwd_gap1", enc_r(4'd0, 11, 10, 1), 16'h0, 1);
		add_entry("fwd_gap1", enc_r(4'd3, 12, 11, 10), 16'h0, 1);
		add_entry("fwd_gap1", enc_r(4'd1, 13, 12, 11), 16'h0, 0);
		// Negative source so SRA has to fill with ones
		add_entry("shifts", enc_llb(2, 8'($urandom()) | 8'h80), 16'h0, 0);
		for (int k = 0; k < 3; k++) begin
			add_entry("shifts", enc_r(4'd4, 3, 2, 4'($urandom())), 16'h0, 0);
			add_entry("shifts", enc_r(4'd5, 4, 2, 4'($urandom())), 16'h0, 0);
			add_entry("shifts", enc_r(4'd6, 5, 2, 4'($urandom())), 16'h0, 0);
			add_entry("shifts", enc_r(4'd6, 6, 5, 4'($urandom())), 16'h0, 1);
		end
		add_entry("jumps", {4'd13, 12'($urandom()) & 12'h7ff}, 16'($urandom()), 0);
		add_entry("jumps", {4'd13, 12'($urandom()) | 12'h800}, 16'($urandom()), 0);
		add_entry("jumps", enc_llb(6, 8'($urandom())), 16'h0, 0);
		add_entry("jumps", enc_r(4'd14, 0, 6, 0), 16'h0, 0);
		add_entry("jumps", enc_r(4'd0, 7, 6, 1), 16'h0, 1);
		add_entry("jumps", enc_r(4'd14, 0, 7, 0), 16'h0, 0);
		// Everything after HLT must be dropped
		add_entry("halt", enc_r(4'd0, 8, 1, 2), 16'h0, 0);
		add_entry("halt", 16'hf000, 16'h0, 0);
		add_entry("halt", enc_llb(9, 8'($urandom())), 16'h0, 0);
		add_entry("halt", enc_r(4'd0, 9, 1, 1), 16'h0, 1);
		add_entry("halt", {4'd13, 12'h010}, 16'h0040, 0);
	endtask

	task automatic finish_group(input string label);
		int waited;
		waited = 0;
		// Results trail the last strobe by at most two cycles
		while ((exp_wb_addr.size() != 0 || exp_j_pc.size() != 0) && waited < 8) begin
			@(negedge clk);
			waited++;
		end
		repeat (4) @(negedge clk);
		if (label == "halt")
			check("halted", 1, halted);
		tests_run++;
		if (error_count == group_errors) begin
			$display("test %s: ok", label);
		end else begin
			$display("test %s: %0d errors", label, error_count - group_errors);
			tests_failed++;
		end
		group_errors = error_count;
	endtask

	// Match results against the queues in the order they arrive
	always @(negedge clk) begin
		if (rst_n && wb_valid) begin
			if (exp_wb_addr.size() == 0) begin
				$display("unexpected writeback to r%0d at %0t ns", wb_addr, $time);
				error_count++;
			end else begin
				check("wb_addr", exp_wb_addr.pop_front(), wb_addr);
				check("wb_data", exp_wb_data.pop_front(), wb_data);
			end
		end
		if (rst_n && j_valid) begin
			if (exp_j_pc.size() == 0) begin
				$display("unexpected jump to %0h at %0t ns", j_pc, $time);
				error_count++;
			end else begin
				check("j_pc", exp_j_pc.pop_front(), j_pc);
			end
		end
	end

	initial begin
		int limit_ns;
		wait (table_ready);
		limit_ns = (tb_instr.size() + 20) * 10 * 4;
		#(limit_ns);
		$display("timeout: the run did not finish within %0d ns", limit_ns);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		instr_valid  = 1'b0;
		instr        = '0;
		pc           = '0;
		model_halted = 1'b0;
		table_ready  = 1'b0;
		error_count  = 0;
		group_errors = 0;
		tests_run    = 0;
		tests_failed = 0;
		foreach (ref_regs[i])
			ref_regs[i] = '0;
		seed_state = $urandom(10198);
		build_table();
		table_ready = 1'b1;

		wait (rst_n);
		@(negedge clk);
		check("wb_valid", 0, wb_valid);
		check("j_valid", 0, j_valid);
		check("halted", 0, halted);
		finish_group("reset");

		for (int i = 0; i < tb_instr.size(); i++) begin
			@(negedge clk);
			instr_valid = 1'b1;
			instr       = tb_instr[i];
			pc          = tb_pc[i];
			model_apply(tb_instr[i], tb_pc[i]);
			repeat (tb_gap[i]) begin
				@(negedge clk);
				instr_valid = 1'b0;
			end
			if (i == tb_instr.size() - 1 || tb_label[i + 1] != tb_label[i]) begin
				@(negedge clk);
				instr_valid = 1'b0;
				finish_group(tb_label[i]);
			end
		end

		if (exp_wb_addr.size() != 0 || exp_j_pc.size() != 0) begin
			$display("results never reported: %0d writebacks, %0d jumps",
				exp_wb_addr.size(), exp_j_pc.size());
			error_count++;
		end
		$display("tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, error_count);
		if (error_count == 0)
			$display("PASS: all tests");
		else
			$display("FAIL: see errors above");
		$finish;
	end

endmodule

// ==== bench/clock_gen.sv ====
// ####################################################################
// Testbench clock and reset, 10 ns period, reset low for 4 cycles
// ####################################################################
`timescale 1ns/1ps

module clock_gen (
	output logic clk,
	output logic rst_n
);

	initial begin
		clk   = 1'b0;
		rst_n = 1'b0;
		forever #5 clk = ~clk;
	end

	initial begin
		repeat (4) @(posedge clk);
		rst_n <= 1'b1;
	end

endmodule

// ==== source/cpu_core.sv ====
// ####################################################################
// Core top: decode and execute stages with the writeback feedback
// ####################################################################
`timescale 1ns/1ps

module cpu_core (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  pipe_pkg::word_t     instr,
	input  pipe_pkg::word_t     pc,
	output logic                wb_valid,
	output pipe_pkg::reg_addr_t wb_addr,
	output pipe_pkg::word_t     wb_data,
	output logic                j_valid,
	output pipe_pkg::word_t     j_pc,
	output logic                halted
);

	logic                ex_valid, ex_we, ex_fwd_we, wb_we;
	pipe_pkg::alu_func_e ex_func;
	pipe_pkg::word_t     ex_a, ex_b, ex_imm, ex_result;
	pipe_pkg::reg_addr_t ex_dst;

	id_stage u_id (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr), .pc(pc),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data),
		.ex_fwd_we(ex_fwd_we), .ex_fwd_dst(ex_dst), .ex_result(ex_result),
		.ex_valid(ex_valid), .ex_func(ex_func), .ex_a(ex_a), .ex_b(ex_b),
		.ex_imm(ex_imm), .ex_dst(ex_dst), .ex_we(ex_we),
		.j_valid(j_valid), .j_pc(j_pc), .halted(halted)
	);

	// Execute feeds its result back to decode for forwarding
	ex_stage u_ex (
		.clk(clk), .rst_n(rst_n), .ex_valid(ex_valid), .ex_func(ex_func),
		.ex_a(ex_a), .ex_b(ex_b), .ex_imm(ex_imm), .ex_dst(ex_dst), .ex_we(ex_we),
		.ex_result(ex_result), .ex_fwd_we(ex_fwd_we), .wb_valid(wb_valid),
		.wb_we(wb_we), .wb_addr(wb_addr), .wb_data(wb_data)
	);

endmodule

// ==== source/ex_stage.sv ====
// ####################################################################
// Execute stage: ALU and the EX/WB pipeline register
// ####################################################################
`timescale 1ns/1ps
`include "core_params.svh"

module ex_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                ex_valid,
	input  pipe_pkg::alu_func_e ex_func,
	input  pipe_pkg::word_t     ex_a,
	input  pipe_pkg::word_t     ex_b,
	input  pipe_pkg::word_t     ex_imm,
	input  pipe_pkg::reg_addr_t ex_dst,
	input  logic                ex_we,
	output pipe_pkg::word_t     ex_result,
	output logic                ex_fwd_we,
	output logic                wb_valid,
	output logic                wb_we,
	output pipe_pkg::reg_addr_t wb_addr,
	output pipe_pkg::word_t     wb_data
);

	localparam int sh_w = $clog2(`CORE_WORD_W);

	logic [sh_w-1:0] shamt;

	assign shamt = ex_b[sh_w-1:0];

	always_comb begin
		case (ex_func)
			pipe_pkg::alu_add:  ex_result = ex_a + ex_b;
			pipe_pkg::alu_sub:  ex_result = ex_a - ex_b;
			pipe_pkg::alu_and:  ex_result = ex_a & ex_b;
			pipe_pkg::alu_nor:  ex_result = ~(ex_a | ex_b);
			pipe_pkg::alu_sll:  ex_result = ex_a << shamt;
			pipe_pkg::alu_srl:  ex_result = ex_a >> shamt;
			// Arithmetic shift keeps the sign bit
			pipe_pkg::alu_sra:  ex_result = pipe_pkg::word_t'($signed(ex_a) >>> shamt);
			pipe_pkg::alu_pass: ex_result = ex_imm;
			default:            ex_result = '0;
		endcase
	end

	// Only a live writing instruction may be forwarded
	assign ex_fwd_we = ex_valid && ex_we;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			wb_valid <= 1'b0;
			wb_we    <= 1'b0;
		end else begin
			wb_valid <= ex_valid;
			wb_we    <= ex_fwd_we;
		end
	end

	always_ff @(posedge clk) begin
		wb_addr <= ex_dst;
		wb_data <= ex_result;
	end

endmodule

// ==== source/id_stage.sv ====
// ####################################################################
// Decode stage: operand read and forwarding, jumps, halt, ID/EX reg
// ####################################################################
`timescale 1ns/1ps
`include "core_params.svh"

module id_stage (
	input  logic                clk,
	input  logic                rst_n,
	input  logic                instr_valid,
	input  pipe_pkg::word_t     instr,
	input  pipe_pkg::word_t     pc,
	input  logic                wb_we,
	input  pipe_pkg::reg_addr_t wb_addr,
	input  pipe_pkg::word_t     wb_data,
	input  logic                ex_fwd_we,
	input  pipe_pkg::reg_addr_t ex_fwd_dst,
	input  pipe_pkg::word_t     ex_result,
	output logic                ex_valid,
	output pipe_pkg::alu_func_e ex_func,
	output pipe_pkg::word_t     ex_a,
	output pipe_pkg::word_t     ex_b,
	output pipe_pkg::word_t     ex_imm,
	output pipe_pkg::reg_addr_t ex_dst,
	output logic                ex_we,
	output logic                j_valid,
	output pipe_pkg::word_t     j_pc,
	output logic                halted
);

	pipe_pkg::reg_addr_t p0_addr, p1_addr, dst_addr;
	logic                re0, re1, we_rf, is_jal, is_jr, is_hlt;
	pipe_pkg::alu_func_e func;
	isa_pkg::imm8_t      imm8;
	isa_pkg::imm12_t     imm12;
	pipe_pkg::word_t     p0, p1, op_a, op_b, jr_val, jal_pc, imm_ext;
	pipe_pkg::fwd_sel_e  sel_a, sel_b, sel_jr;
	logic                accept;

	function automatic pipe_pkg::word_t fwd_pick(input pipe_pkg::fwd_sel_e sel,
			input pipe_pkg::word_t rf_val, input pipe_pkg::word_t ex_val,
			input pipe_pkg::word_t wb_val);
		case (sel)
			pipe_pkg::fwd_ex: return ex_val;
			pipe_pkg::fwd_wb: return wb_val;
			default:          return rf_val;
		endcase
	endfunction

	inst_decode u_dec (
		.instr(instr), .p0_addr(p0_addr), .p1_addr(p1_addr), .dst_addr(dst_addr),
		.re0(re0), .re1(re1), .we_rf(we_rf), .func(func), .imm8(imm8), .imm12(imm12),
		.is_jal(is_jal), .is_jr(is_jr), .is_hlt(is_hlt)
	);

	reg_file u_rf (
		.clk(clk), .rst_n(rst_n), .p0_addr(p0_addr), .p1_addr(p1_addr),
		.dst_addr(wb_addr), .we(wb_we), .dst(wb_data), .p0(p0), .p1(p1)
	);

	forward_ctrl u_fwd_a (
		.src_addr(p0_addr), .ex_dst(ex_fwd_dst), .wb_dst(wb_addr),
		.ex_we(ex_fwd_we), .wb_we(wb_we), .sel(sel_a)
	);
	forward_ctrl u_fwd_b (
		.src_addr(p1_addr), .ex_dst(ex_fwd_dst), .wb_dst(wb_addr),
		.ex_we(ex_fwd_we), .wb_we(wb_we), .sel(sel_b)
	);
	// JR target register sits in the rs field
	forward_ctrl u_fwd_jr (
		.src_addr(p0_addr), .ex_dst(ex_fwd_dst), .wb_dst(wb_addr),
		.ex_we(ex_fwd_we), .wb_we(wb_we), .sel(sel_jr)
	);

	assign accept = instr_valid && !halted;

	assign op_a = re0 ? fwd_pick(sel_a, p0, ex_result, wb_data) : '0;
	// Shifts carry the amount in the rt field instead of a register
	assign op_b = re1 ? fwd_pick(sel_b, p1, ex_result, wb_data)
		: {{(`CORE_WORD_W - `CORE_RADDR_W){1'b0}}, p1_addr};

	assign jr_val  = fwd_pick(sel_jr, p0, ex_result, wb_data);
	assign jal_pc  = pc + {{(`CORE_WORD_W - `CORE_IMM12_W){imm12[`CORE_IMM12_W-1]}}, imm12};
	assign imm_ext = {{(`CORE_WORD_W - `CORE_IMM8_W){imm8[`CORE_IMM8_W-1]}}, imm8};

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ex_valid <= 1'b0;
			ex_we    <= 1'b0;
			j_valid  <= 1'b0;
			halted   <= 1'b0;
		end else begin
			ex_valid <= accept && we_rf;
			ex_we    <= we_rf && (dst_addr != '0);
			j_valid  <= accept && (is_jal || is_jr);
			halted   <= halted || (accept && is_hlt);
		end
	end

	// Payload of ID/EX and the jump target
	always_ff @(posedge clk) begin
		ex_func <= func;
		ex_a    <= op_a;
		ex_b    <= op_b;
		ex_imm  <= imm_ext;
		ex_dst  <= dst_addr;
		j_pc    <= is_jal ? jal_pc : jr_val;
	end

	a_no_issue_halted: assert property (@(posedge clk) disable iff (!rst_n)
		halted |=> !ex_valid);

endmodule

// ==== source/forward_ctrl.sv ====
// ####################################################################
// Forwarding select: execute result, then writeback, then regfile
// ####################################################################
`timescale 1ns/1ps

module forward_ctrl (
	input  pipe_pkg::reg_addr_t src_addr,
	input  pipe_pkg::reg_addr_t ex_dst,
	input  pipe_pkg::reg_addr_t wb_dst,
	input  logic                ex_we,
	input  logic                wb_we,
	output pipe_pkg::fwd_sel_e  sel
);

	logic src_live;

	// r0 is constant, so it never takes a forwarded value
	assign src_live = (src_addr != '0);

	always_comb begin
		if (src_live && ex_we && ex_dst == src_addr) begin
			sel = pipe_pkg::fwd_ex;
		end else if (src_live && wb_we && wb_dst == src_addr) begin
			sel = pipe_pkg::fwd_wb;
		end else begin
			sel = pipe_pkg::fwd_reg;
		end
	end

endmodule

// ==== source/reg_file.sv ====
// ####################################################################
// Register file, two async read ports and one write port, r0 is zero
// ####################################################################
`timescale 1ns/1ps
`include "core_params.svh"

module reg_file (
	input  logic                clk,
	input  logic                rst_n,
	input  pipe_pkg::reg_addr_t p0_addr,
	input  pipe_pkg::reg_addr_t p1_addr,
	input  pipe_pkg::reg_addr_t dst_addr,
	input  logic                we,
	input  pipe_pkg::word_t     dst,
	output pipe_pkg::word_t     p0,
	output pipe_pkg::word_t     p1
);

	pipe_pkg::word_t regs [`CORE_NREGS];

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			for (int i = 0; i < `CORE_NREGS; i++) begin
				regs[i] <= '0;
			end
		end else if (we && dst_addr != '0) begin
			regs[dst_addr] <= dst;
		end
	end

	// Same-cycle write and read is resolved by the forwarding path
	assign p0 = (p0_addr == '0) ? '0 : regs[p0_addr];
	assign p1 = (p1_addr == '0) ? '0 : regs[p1_addr];

	a_dst_known: assert property (@(posedge clk) disable iff (!rst_n)
		we |-> !$isunknown(dst_addr));

endmodule

// ==== source/inst_decode.sv ====
// ####################################################################
// Instruction decoder: register addresses, enables, ALU function
// ####################################################################
`timescale 1ns/1ps
`include "core_params.svh"

module inst_decode (
	input  pipe_pkg::word_t     instr,
	output pipe_pkg::reg_addr_t p0_addr,
	output pipe_pkg::reg_addr_t p1_addr,
	output pipe_pkg::reg_addr_t dst_addr,
	output logic                re0,
	output logic                re1,
	output logic                we_rf,
	output pipe_pkg::alu_func_e func,
	output isa_pkg::imm8_t      imm8,
	output isa_pkg::imm12_t     imm12,
	output logic                is_jal,
	output logic                is_jr,
	output logic                is_hlt
);

	isa_pkg::opcode_e opcode;

	// Field extraction does not depend on the opcode
	assign opcode   = isa_pkg::opcode_e'(instr[`CORE_OP_LSB +: `CORE_OP_W]);
	assign dst_addr = instr[`CORE_RD_LSB +: `CORE_RADDR_W];
	assign p0_addr  = instr[`CORE_RS_LSB +: `CORE_RADDR_W];
	// For shifts this field is the shift amount, not a register
	assign p1_addr  = instr[`CORE_RT_LSB +: `CORE_RADDR_W];
	assign imm8     = instr[`CORE_IMM8_W-1:0];
	assign imm12    = instr[`CORE_IMM12_W-1:0];

	always_comb begin
		re0    = 1'b0;
		re1    = 1'b0;
		we_rf  = 1'b0;
		func   = pipe_pkg::alu_add;
		is_jal = 1'b0;
		is_jr  = 1'b0;
		is_hlt = 1'b0;
		case (opcode)
			isa_pkg::op_add: begin
				{re0, re1, we_rf} = 3'b111;
				func = pipe_pkg::alu_add;
			end
			isa_pkg::op_sub: begin
				{re0, re1, we_rf} = 3'b111;
				func = pipe_pkg::alu_sub;
			end
			isa_pkg::op_and: begin
				{re0, re1, we_rf} = 3'b111;
				func = pipe_pkg::alu_and;
			end
			isa_pkg::op_nor: begin
				{re0, re1, we_rf} = 3'b111;
				func = pipe_pkg::alu_nor;
			end
			isa_pkg::op_sll: begin
				{re0, we_rf} = 2'b11;
				func = pipe_pkg::alu_sll;
			end
			isa_pkg::op_srl: begin
				{re0, we_rf} = 2'b11;
				func = pipe_pkg::alu_srl;
			end
			isa_pkg::op_sra: begin
				{re0, we_rf} = 2'b11;
				func = pipe_pkg::alu_sra;
			end
			isa_pkg::op_llb: begin
				we_rf = 1'b1;
				func  = pipe_pkg::alu_pass;
			end
			isa_pkg::op_jal: is_jal = 1'b1;
			isa_pkg::op_jr: begin
				re0   = 1'b1;
				is_jr = 1'b1;
			end
			isa_pkg::op_hlt: is_hlt = 1'b1;
			default: ;
		endcase
	end

	// Jump kinds are exclusive or the target mux in decode is ambiguous
	always_comb begin
		assert final (!(is_jal && is_jr))
			else $error("decoder flags JAL and JR together");
	end

endmodule

// ==== source/pipe_pkg.sv ====
// ####################################################################
// Datapath types shared by the pipeline stages
// ####################################################################
`include "core_params.svh"

package pipe_pkg;

	typedef logic [`CORE_WORD_W-1:0] word_t;
	typedef logic [`CORE_RADDR_W-1:0] reg_addr_t;

	// Pass hands the sign-extended LLB immediate straight through
	typedef enum logic [2:0] {
		alu_add, alu_sub, alu_and, alu_nor, alu_sll, alu_srl, alu_sra, alu_pass
	} alu_func_e;

	// Operand source chosen by the forwarding logic
	typedef enum logic [1:0] {
		fwd_reg, fwd_ex, fwd_wb
	} fwd_sel_e;

endpackage

// ==== source/isa_pkg.sv ====
// ####################################################################
// Instruction set encoding: opcodes and immediate field types
// ####################################################################
`include "core_params.svh"

package isa_pkg;

	// Opcodes not listed here decode as no-operation
	typedef enum logic [`CORE_OP_W-1:0] {
		op_add = 4'd0,
		op_sub = 4'd1,
		op_and = 4'd2,
		op_nor = 4'd3,
		op_sll = 4'd4,
		op_srl = 4'd5,
		op_sra = 4'd6,
		op_llb = 4'd8,
		op_jal = 4'd13,
		op_jr  = 4'd14,
		op_hlt = 4'd15
	} opcode_e;

	// LLB immediate, bits 7:0
	typedef logic [`CORE_IMM8_W-1:0] imm8_t;

	// JAL signed offset, bits 11:0
	typedef logic [`CORE_IMM12_W-1:0] imm12_t;

endpackage

// ==== include/core_params.svh ====
// ####################################################################
// Core sizing and instruction field positions
// ####################################################################
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// Datapath and register file sizing
`define CORE_WORD_W   16
`define CORE_NREGS    16
`define CORE_RADDR_W  4

// Instruction fields, given as lsb position and width
`define CORE_OP_W     4
`define CORE_OP_LSB   12
`define CORE_RD_LSB   8
`define CORE_RS_LSB   4
`define CORE_RT_LSB   0
`define CORE_IMM8_W   8
`define CORE_IMM12_W  12

`endif
